// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := mem_wrapper_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/amo_alu.sv
/* Atomic operation datapath */

`timescale 1ns/1ps

module amo_alu (
    input  mem_pkg::amo_op_e               op_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0] old_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0] operand_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] result_o
);

    import mem_pkg::*;

    logic old_is_less;

    // Signed ordering for MAX and MIN
    assign old_is_less = $signed(old_i) < $signed(operand_i);

    always_comb begin
        case (op_i)
            SWAP:    result_o = operand_i;
            ADD:     result_o = old_i + operand_i;
            AND:     result_o = old_i & operand_i;
            OR:      result_o = old_i | operand_i;
            XOR:     result_o = old_i ^ operand_i;
            MAX:     result_o = old_is_less ? operand_i : old_i;
            MIN:     result_o = old_is_less ? old_i : operand_i;
            // Unused encoding leaves memory unchanged
            default: result_o = old_i;
        endcase
    end

endmodule

// File: source/beat_counter.sv
/* Refill beat counter */

`timescale 1ns/1ps

module beat_counter #(
    parameter int LINE_BEATS = mem_pkg::DEFAULT_LINE_BEATS
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       start_i,
    input  logic       step_i,
    output logic [1:0] beat_o,
    output logic       last_o
);

    assign last_o = (32'(beat_o) == LINE_BEATS - 1);

    always_ff @(posedge clk_i) begin
        if (rst_i || start_i) begin
            beat_o <= '0;
        end else if (step_i) begin
            // Wrap back to zero after the last beat of the line
            if (last_o) begin
                beat_o <= '0;
            end else begin
                beat_o <= beat_o + 2'd1;
            end
        end
    end

endmodule

// File: source/bootrom.sv
/* Boot ROM */

`timescale 1ns/1ps

module bootrom #(
    parameter int BROM_WORDS = mem_pkg::DEFAULT_BROM_WORDS
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          req_valid_i,
    input  logic [3:0]                    req_addr_i,
    output logic                          resp_valid_o,
    output logic [mem_pkg::DATA_WIDTH-1:0] resp_data_o
);

    import mem_pkg::*;

    // Boot program followed by its data words
    localparam logic [DATA_WIDTH-1:0] ROM_TABLE [16] = '{
        32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_a283,
        32'h0002_8067, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
        32'h8000_0000, 32'h0000_0000, 32'hdead_beef, 32'hcafe_f00d,
        32'h1234_5678, 32'h0bad_c0de, 32'h5555_aaaa, 32'hffff_0000
    };

    logic [DATA_WIDTH-1:0] rom_word;

    // Words past the populated range read as zero
    assign rom_word = (32'(req_addr_i) < BROM_WORDS) ? ROM_TABLE[req_addr_i] : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            resp_data_o <= rom_word;
        end
    end

endmodule

// File: source/data_sram.sv
/* Data SRAM */

`timescale 1ns/1ps

module data_sram #(
    parameter int SRAM_DEPTH = mem_pkg::DEFAULT_SRAM_DEPTH
) (
    input  logic                           clk_i,
    input  logic                           cmd_valid_i,
    input  mem_pkg::sram_cmd_t             cmd_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] rdata_o
);

    import mem_pkg::*;

    logic [DATA_WIDTH-1:0] mem [SRAM_DEPTH];

    // One access per cycle, write or registered read
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            if (cmd_i.we) begin
                mem[cmd_i.addr] <= cmd_i.wdata;
            end else begin
                rdata_o <= mem[cmd_i.addr];
            end
        end
    end

endmodule

// File: source/mem_pkg.sv
/* Memory subsystem shared types */

package mem_pkg;

    // Word and address sizes
    localparam int DATA_WIDTH        = 32;
    localparam int DCACHE_ADDR_WIDTH = 8;

    // Default module sizes, overridden from the top level
    localparam int DEFAULT_SRAM_DEPTH = 256;
    localparam int DEFAULT_LINE_BEATS = 4;
    localparam int DEFAULT_BROM_WORDS = 16;

    typedef enum logic [1:0] {
        LOAD  = 2'd0,
        STORE = 2'd1,
        AMO   = 2'd2
    } dcache_op_e;

    // MAX and MIN compare as signed numbers
    typedef enum logic [2:0] {
        SWAP = 3'd0,
        ADD  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        MAX  = 3'd5,
        MIN  = 3'd6
    } amo_op_e;

    typedef struct packed {
        dcache_op_e                   op;
        amo_op_e                      amo_op;
        logic [DCACHE_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]        wdata;
    } dcache_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
    } dcache_resp_t;

    typedef struct packed {
        logic                         we;
        logic [DCACHE_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]        wdata;
    } sram_cmd_t;

endpackage

// File: source/mem_sequencer.sv
/* Memory request sequencer */

`timescale 1ns/1ps

module mem_sequencer #(
    parameter int LINE_BEATS = mem_pkg::DEFAULT_LINE_BEATS
) (
    input  logic                           clk_i,
    input  logic                           rst_i,

    input  logic                           icache_req_valid_i,
    input  logic [5:0]                     icache_req_line_i,
    output logic                           icache_beat_valid_o,
    output logic [mem_pkg::DATA_WIDTH-1:0] icache_beat_data_o,
    output logic [1:0]                     icache_beat_idx_o,

    input  logic                           dcache_req_valid_i,
    input  mem_pkg::dcache_req_t           dcache_req_i,
    output logic                           dcache_resp_valid_o,
    output mem_pkg::dcache_resp_t          dcache_resp_o,
    output logic                           busy_o,

    output logic                           sram_cmd_valid_o,
    output mem_pkg::sram_cmd_t             sram_cmd_o,
    input  logic [mem_pkg::DATA_WIDTH-1:0] sram_rdata_i,

    output mem_pkg::amo_op_e               amo_op_o,
    output logic [mem_pkg::DATA_WIDTH-1:0] amo_operand_o,
    input  logic [mem_pkg::DATA_WIDTH-1:0] amo_result_i,

    output logic                           beat_start_o,
    output logic                           beat_step_o,
    input  logic [1:0]                     beat_idx_i,
    input  logic                           beat_last_i
);

    import mem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        REFILL,
        REFILL_DRAIN,
        DC_READ,
        DC_WRITE,
        AMO_MODIFY,
        RESPOND
    } state_e;

    state_e                       state_q;
    state_e                       state_d;
    dcache_req_t                  req_q;
    logic [5:0]                   line_q;
    logic [DCACHE_ADDR_WIDTH-1:0] refill_addr;

    // Word address of the current beat within the line
    assign refill_addr = DCACHE_ADDR_WIDTH'(32'(line_q) * LINE_BEATS + 32'(beat_idx_i));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // Instruction refill has priority over the data cache
                if (icache_req_valid_i) begin
                    state_d = REFILL;
                end else if (dcache_req_valid_i) begin
                    state_d = (dcache_req_i.op == STORE) ? DC_WRITE : DC_READ;
                end
            end
            REFILL:       state_d = beat_last_i ? REFILL_DRAIN : REFILL;
            REFILL_DRAIN: state_d = IDLE;
            DC_READ:      state_d = (req_q.op == AMO) ? AMO_MODIFY : RESPOND;
            DC_WRITE:     state_d = RESPOND;
            AMO_MODIFY:   state_d = RESPOND;
            RESPOND:      state_d = IDLE;
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q             <= IDLE;
            icache_beat_valid_o <= 1'b0;
        end else begin
            state_q             <= state_d;
            // Read data lands one cycle after each refill read
            icache_beat_valid_o <= (state_q == REFILL);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            if (icache_req_valid_i) begin
                line_q <= icache_req_line_i;
            end else if (dcache_req_valid_i) begin
                req_q <= dcache_req_i;
            end
        end
        if (state_q == REFILL) begin
            icache_beat_idx_o <= beat_idx_i;
        end
    end

    // SRAM command for each state
    always_comb begin
        sram_cmd_valid_o = 1'b0;
        sram_cmd_o.we    = 1'b0;
        sram_cmd_o.addr  = req_q.addr;
        sram_cmd_o.wdata = req_q.wdata;
        case (state_q)
            REFILL: begin
                sram_cmd_valid_o = 1'b1;
                sram_cmd_o.addr  = refill_addr;
            end
            DC_READ: begin
                sram_cmd_valid_o = 1'b1;
            end
            DC_WRITE: begin
                sram_cmd_valid_o = 1'b1;
                sram_cmd_o.we    = 1'b1;
            end
            AMO_MODIFY: begin
                sram_cmd_valid_o = 1'b1;
                sram_cmd_o.we    = 1'b1;
                sram_cmd_o.wdata = amo_result_i;
            end
            default: begin
            end
        endcase
    end

    // Read register keeps the old word through the AMO write
    always_comb begin
        dcache_resp_o.data = (req_q.op == STORE) ? '0 : sram_rdata_i;
    end

    assign dcache_resp_valid_o = (state_q == RESPOND);
    assign busy_o              = (state_q != IDLE);
    assign icache_beat_data_o  = sram_rdata_i;

    assign amo_op_o      = req_q.amo_op;
    assign amo_operand_o = req_q.wdata;

    assign beat_start_o = (state_q == IDLE) && icache_req_valid_i;
    assign beat_step_o  = (state_q == REFILL);

endmodule

// File: source/mem_wrapper.sv
/* Memory subsystem top level */

`timescale 1ns/1ps

module mem_wrapper #(
    parameter int SRAM_DEPTH = mem_pkg::DEFAULT_SRAM_DEPTH,
    parameter int LINE_BEATS = mem_pkg::DEFAULT_LINE_BEATS,
    parameter int BROM_WORDS = mem_pkg::DEFAULT_BROM_WORDS
) (
    input  logic                           clk_i,
    input  logic                           rst_i,

    // Bootrom port
    input  logic                           brom_req_valid_i,
    input  logic [3:0]                     brom_req_addr_i,
    output logic                           brom_resp_valid_o,
    output logic [mem_pkg::DATA_WIDTH-1:0] brom_resp_data_o,

    // Instruction cache refill port
    input  logic                           icache_req_valid_i,
    input  logic [5:0]                     icache_req_line_i,
    output logic                           icache_beat_valid_o,
    output logic [mem_pkg::DATA_WIDTH-1:0] icache_beat_data_o,
    output logic [1:0]                     icache_beat_idx_o,

    // Data cache port
    input  logic                           dcache_req_valid_i,
    input  mem_pkg::dcache_req_t           dcache_req_i,
    output logic                           dcache_resp_valid_o,
    output mem_pkg::dcache_resp_t          dcache_resp_o,
    output logic                           busy_o
);

    import mem_pkg::*;

    logic                  sram_cmd_valid;
    sram_cmd_t             sram_cmd;
    logic [DATA_WIDTH-1:0] sram_rdata;
    amo_op_e               amo_op;
    logic [DATA_WIDTH-1:0] amo_operand;
    logic [DATA_WIDTH-1:0] amo_result;
    logic                  beat_start;
    logic                  beat_step;
    logic [1:0]            beat_idx;
    logic                  beat_last;

    bootrom #(
        .BROM_WORDS(BROM_WORDS)
    ) bootrom_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (brom_req_valid_i),
        .req_addr_i  (brom_req_addr_i),
        .resp_valid_o(brom_resp_valid_o),
        .resp_data_o (brom_resp_data_o)
    );

    data_sram #(
        .SRAM_DEPTH(SRAM_DEPTH)
    ) data_sram_i (
        .clk_i      (clk_i),
        .cmd_valid_i(sram_cmd_valid),
        .cmd_i      (sram_cmd),
        .rdata_o    (sram_rdata)
    );

    // Old word comes straight from the SRAM read register
    amo_alu amo_alu_i (
        .op_i     (amo_op),
        .old_i    (sram_rdata),
        .operand_i(amo_operand),
        .result_o (amo_result)
    );

    beat_counter #(
        .LINE_BEATS(LINE_BEATS)
    ) beat_counter_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .start_i(beat_start),
        .step_i (beat_step),
        .beat_o (beat_idx),
        .last_o (beat_last)
    );

    mem_sequencer #(
        .LINE_BEATS(LINE_BEATS)
    ) mem_sequencer_i (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .icache_req_valid_i (icache_req_valid_i),
        .icache_req_line_i  (icache_req_line_i),
        .icache_beat_valid_o(icache_beat_valid_o),
        .icache_beat_data_o (icache_beat_data_o),
        .icache_beat_idx_o  (icache_beat_idx_o),
        .dcache_req_valid_i (dcache_req_valid_i),
        .dcache_req_i       (dcache_req_i),
        .dcache_resp_valid_o(dcache_resp_valid_o),
        .dcache_resp_o      (dcache_resp_o),
        .busy_o             (busy_o),
        .sram_cmd_valid_o   (sram_cmd_valid),
        .sram_cmd_o         (sram_cmd),
        .sram_rdata_i       (sram_rdata),
        .amo_op_o           (amo_op),
        .amo_operand_o      (amo_operand),
        .amo_result_i       (amo_result),
        .beat_start_o       (beat_start),
        .beat_step_o        (beat_step),
        .beat_idx_i         (beat_idx),
        .beat_last_i        (beat_last)
    );

endmodule

// File: sources.f
source/mem_pkg.sv
source/bootrom.sv
source/data_sram.sv
source/amo_alu.sv
source/beat_counter.sv
source/mem_sequencer.sv
source/mem_wrapper.sv
tb/mem_wrapper_props.sv
tb/mem_wrapper_tb.sv

// File: tb/mem_wrapper_props.sv
/* Sequencer strobe checks */

`timescale 1ns/1ps

module mem_wrapper_props #(
    parameter int LINE_BEATS = 4
) (
    input logic       clk_i,
    input logic       rst_i,
    input logic       busy_o,
    input logic       icache_req_valid_i,
    input logic       icache_beat_valid_o,
    input logic [1:0] icache_beat_idx_o,
    input logic       dcache_resp_valid_o
);

    logic refill_accept;

    assign refill_accept = icache_req_valid_i && !busy_o;

    // Sequencer comes out of reset idle
    assert property (@(posedge clk_i) rst_i |=> !busy_o)
        else $error("busy_o is high after reset");

    // Beat 0 arrives two cycles after an accepted refill
    assert property (@(posedge clk_i) disable iff (rst_i)
        $past(refill_accept, 2) |-> icache_beat_valid_o && icache_beat_idx_o == 2'd0)
        else $error("refill did not start with beat 0");

    // Beats follow back to back and stop after the last one of the line
    assert property (@(posedge clk_i) disable iff (rst_i)
        icache_beat_valid_o |=> (32'($past(icache_beat_idx_o)) == LINE_BEATS - 1) ?
            !icache_beat_valid_o :
            (icache_beat_valid_o && icache_beat_idx_o == $past(icache_beat_idx_o) + 2'd1))
        else $error("refill beats are not consecutive with rising indices");

    assert property (@(posedge clk_i) disable iff (rst_i)
        dcache_resp_valid_o |=> !dcache_resp_valid_o)
        else $error("dcache response held for two cycles");

endmodule

bind mem_sequencer mem_wrapper_props #(
    .LINE_BEATS(LINE_BEATS)
) mem_wrapper_props_i (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .busy_o             (busy_o),
    .icache_req_valid_i (icache_req_valid_i),
    .icache_beat_valid_o(icache_beat_valid_o),
    .icache_beat_idx_o  (icache_beat_idx_o),
    .dcache_resp_valid_o(dcache_resp_valid_o)
);

// File: tb/mem_wrapper_tb.sv
/* Memory subsystem testbench */

`timescale 1ns/1ps

module mem_wrapper_tb;

    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;

    // Which response strobe a wait watches
    localparam int PULSE_BEAT   = 0;
    localparam int PULSE_DCACHE = 1;

    // Refill variants
    localparam int REFILL_PLAIN = 0;
    localparam int REFILL_BOTH  = 1;
    localparam int REFILL_BUSY  = 2;

    logic         clk;
    logic         rst;
    logic         brom_req_valid;
    logic [3:0]   brom_req_addr;
    logic         brom_resp_valid;
    logic [31:0]  brom_resp_data;
    logic         icache_req_valid;
    logic [5:0]   icache_req_line;
    logic         icache_beat_valid;
    logic [31:0]  icache_beat_data;
    logic [1:0]   icache_beat_idx;
    logic         dcache_req_valid;
    dcache_req_t  dcache_req;
    logic         dcache_resp_valid;
    dcache_resp_t dcache_resp;
    logic         busy;

    mem_wrapper #(
        .SRAM_DEPTH(256),
        .LINE_BEATS(4),
        .BROM_WORDS(16)
    ) mem_wrapper_i (
        .clk_i              (clk),
        .rst_i              (rst),
        .brom_req_valid_i   (brom_req_valid),
        .brom_req_addr_i    (brom_req_addr),
        .brom_resp_valid_o  (brom_resp_valid),
        .brom_resp_data_o   (brom_resp_data),
        .icache_req_valid_i (icache_req_valid),
        .icache_req_line_i  (icache_req_line),
        .icache_beat_valid_o(icache_beat_valid),
        .icache_beat_data_o (icache_beat_data),
        .icache_beat_idx_o  (icache_beat_idx),
        .dcache_req_valid_i (dcache_req_valid),
        .dcache_req_i       (dcache_req),
        .dcache_resp_valid_o(dcache_resp_valid),
        .dcache_resp_o      (dcache_resp),
        .busy_o             (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %08h actual %08h", test_name, expected, actual);
            fail_run("Response value mismatch");
        end
    endtask

    function automatic logic pulse_seen(input int which);
        case (which)
            PULSE_BEAT: return icache_beat_valid;
            default:    return dcache_resp_valid;
        endcase
    endfunction

    // Outputs are sampled on the falling edge, half a cycle after they change
    task automatic wait_pulse(input string test_name, input int which);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!pulse_seen(which)) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("Timed out waiting for a response in test %s", test_name));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_idle(input string test_name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("Memory stayed busy too long in test %s", test_name));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // Bootrom data is due in the cycle right after each request edge
    task automatic run_brom(input string test_name, input logic [3:0] addr, input logic pair,
                            input logic [31:0] exp0, input logic [31:0] exp1);
        @(posedge clk);
        brom_req_valid <= 1'b1;
        brom_req_addr  <= addr;
        @(posedge clk);
        // A pair keeps the request high for a second, back-to-back read
        if (pair) begin
            brom_req_addr <= addr + 4'd1;
        end else begin
            brom_req_valid <= 1'b0;
        end
        @(negedge clk);
        check_value(test_name, 32'd1, 32'(brom_resp_valid));
        check_value(test_name, exp0, brom_resp_data);
        if (pair) begin
            @(posedge clk);
            brom_req_valid <= 1'b0;
            @(negedge clk);
            check_value(test_name, 32'd1, 32'(brom_resp_valid));
            check_value(test_name, exp1, brom_resp_data);
        end
    endtask

    task automatic run_dcache(input string test_name, input dcache_req_t req,
                              input logic [31:0] expected);
        wait_idle(test_name);
        @(posedge clk);
        dcache_req_valid <= 1'b1;
        dcache_req       <= req;
        @(posedge clk);
        dcache_req_valid <= 1'b0;
        wait_pulse(test_name, PULSE_DCACHE);
        check_value(test_name, expected, dcache_resp.data);
    endtask

    task automatic run_refill(input string test_name, input logic [5:0] line_idx,
                              input int mode, input logic [31:0] wdata,
                              input logic [31:0] exp0, input logic [31:0] exp1,
                              input logic [31:0] exp2, input logic [31:0] exp3);
        logic [31:0] expected [4];
        dcache_req_t stray;
        expected[0]  = exp0;
        expected[1]  = exp1;
        expected[2]  = exp2;
        expected[3]  = exp3;
        // Store that the sequencer must drop, aimed at the first word of the line
        stray.op     = STORE;
        stray.amo_op = SWAP;
        stray.addr   = {line_idx, 2'b00};
        stray.wdata  = wdata;
        wait_idle(test_name);
        @(posedge clk);
        icache_req_valid <= 1'b1;
        icache_req_line  <= line_idx;
        dcache_req_valid <= (mode == REFILL_BOTH);
        dcache_req       <= stray;
        @(posedge clk);
        icache_req_valid <= 1'b0;
        dcache_req_valid <= (mode == REFILL_BUSY);
        if (mode == REFILL_BUSY) begin
            @(negedge clk);
            check_value(test_name, 32'd1, 32'(busy));
            @(posedge clk);
            dcache_req_valid <= 1'b0;
        end
        for (int k = 0; k < 4; k++) begin
            wait_pulse(test_name, PULSE_BEAT);
            check_value(test_name, 32'(k), 32'(icache_beat_idx));
            check_value(test_name, expected[k], icache_beat_data);
        end
    endtask

    initial begin
        string       line;
        string       test_name;
        string       port;
        string       op;
        string       amo_name;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp0;
        logic [31:0] exp1;
        logic [31:0] exp2;
        logic [31:0] exp3;
        int          fd;
        int          fields;
        int          mode;
        int          test_count;
        dcache_req_t req;

        rst              <= 1'b1;
        brom_req_valid   <= 1'b0;
        brom_req_addr    <= '0;
        icache_req_valid <= 1'b0;
        icache_req_line  <= '0;
        dcache_req_valid <= 1'b0;
        dcache_req       <= '0;
        test_count = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("tb/mem_wrapper_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the tests file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %s %s %h %h %s %h %h %h %h", test_name, port, op,
                             addr, wdata, amo_name, exp0, exp1, exp2, exp3);
            if (fields != 10) begin
                fail_run($sformatf("Malformed line in the tests file: %s", line));
            end
            if (port == "brom") begin
                run_brom(test_name, addr[3:0], op == "rd2", exp0, exp1);
            end else if (port == "icache") begin
                if (op == "refill") begin
                    mode = REFILL_PLAIN;
                end else if (op == "refill_both") begin
                    mode = REFILL_BOTH;
                end else if (op == "refill_busy") begin
                    mode = REFILL_BUSY;
                end else begin
                    fail_run($sformatf("Unknown refill kind in test %s", test_name));
                end
                run_refill(test_name, addr[5:0], mode, wdata, exp0, exp1, exp2, exp3);
            end else if (port == "dcache") begin
                req.addr  = addr[7:0];
                req.wdata = wdata;
                if (op == "load") begin
                    req.op = LOAD;
                end else if (op == "store") begin
                    req.op = STORE;
                end else begin
                    req.op = AMO;
                end
                if (amo_name == "add") begin
                    req.amo_op = ADD;
                end else if (amo_name == "and") begin
                    req.amo_op = AND;
                end else if (amo_name == "or") begin
                    req.amo_op = OR;
                end else if (amo_name == "xor") begin
                    req.amo_op = XOR;
                end else if (amo_name == "max") begin
                    req.amo_op = MAX;
                end else if (amo_name == "min") begin
                    req.amo_op = MIN;
                end else begin
                    req.amo_op = SWAP;
                end
                run_dcache(test_name, req, exp0);
            end else begin
                fail_run($sformatf("Unknown port in test %s", test_name));
            end
            test_count++;
        end
        $fclose(fd);

        if (test_count == 0) begin
            fail_run("The tests file held no tests");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: tb/mem_wrapper_tests.txt
# name port op addr wdata amo exp0 exp1 exp2 exp3 (hex fields, unused ones zero)
# icache addr is a line index; refill_both and refill_busy also send a store to word line*4
brom_first      brom   rd          0  00000000 -    00000297 00000000 00000000 00000000
brom_magic      brom   rd          a  00000000 -    deadbeef 00000000 00000000 00000000
brom_pair_lo    brom   rd2         b  00000000 -    cafef00d 12345678 00000000 00000000
brom_pair_hi    brom   rd2         e  00000000 -    5555aaaa ffff0000 00000000 00000000
brom_reset_vec  brom   rd          8  00000000 -    80000000 00000000 00000000 00000000
st_line4_w0     dcache store       10 11111111 -    00000000 00000000 00000000 00000000
st_line4_w1     dcache store       11 22222222 -    00000000 00000000 00000000 00000000
st_line4_w2     dcache store       12 33333333 -    00000000 00000000 00000000 00000000
st_line4_w3     dcache store       13 44444444 -    00000000 00000000 00000000 00000000
ld_line4_w0     dcache load        10 00000000 -    11111111 00000000 00000000 00000000
ld_line4_w3     dcache load        13 00000000 -    44444444 00000000 00000000 00000000
refill_line4    icache refill      4  00000000 -    11111111 22222222 33333333 44444444
st_add_init     dcache store       20 ffffffff -    00000000 00000000 00000000 00000000
amo_add_wrap    dcache amo         20 00000002 add  ffffffff 00000000 00000000 00000000
ld_add_wrap     dcache load        20 00000000 -    00000001 00000000 00000000 00000000
st_swap_init    dcache store       21 12345678 -    00000000 00000000 00000000 00000000
amo_swap        dcache amo         21 9abcdef0 swap 12345678 00000000 00000000 00000000
ld_swap         dcache load        21 00000000 -    9abcdef0 00000000 00000000 00000000
st_logic_init   dcache store       22 f0f0f0f0 -    00000000 00000000 00000000 00000000
amo_and         dcache amo         22 0ff00ff0 and  f0f0f0f0 00000000 00000000 00000000
ld_and          dcache load        22 00000000 -    00f000f0 00000000 00000000 00000000
amo_or          dcache amo         22 0000000f or   00f000f0 00000000 00000000 00000000
ld_or           dcache load        22 00000000 -    00f000ff 00000000 00000000 00000000
amo_xor         dcache amo         22 ffffffff xor  00f000ff 00000000 00000000 00000000
ld_xor          dcache load        22 00000000 -    ff0fff00 00000000 00000000 00000000
st_signed_init  dcache store       23 fffffff0 -    00000000 00000000 00000000 00000000
amo_max         dcache amo         23 00000003 max  fffffff0 00000000 00000000 00000000
ld_max          dcache load        23 00000000 -    00000003 00000000 00000000 00000000
amo_min         dcache amo         23 fffffff0 min  00000003 00000000 00000000 00000000
ld_min          dcache load        23 00000000 -    fffffff0 00000000 00000000 00000000
amo_min_neg     dcache amo         23 7fffffff min  fffffff0 00000000 00000000 00000000
ld_min_neg      dcache load        23 00000000 -    fffffff0 00000000 00000000 00000000
st_line12_w0    dcache store       30 aaaa0000 -    00000000 00000000 00000000 00000000
st_line12_w1    dcache store       31 aaaa0001 -    00000000 00000000 00000000 00000000
st_line12_w2    dcache store       32 aaaa0002 -    00000000 00000000 00000000 00000000
st_line12_w3    dcache store       33 aaaa0003 -    00000000 00000000 00000000 00000000
refill_both     icache refill_both c  5a5a5a5a -    aaaa0000 aaaa0001 aaaa0002 aaaa0003
ld_after_both   dcache load        30 00000000 -    aaaa0000 00000000 00000000 00000000
refill_busy     icache refill_busy c  6b6b6b6b -    aaaa0000 aaaa0001 aaaa0002 aaaa0003
ld_after_busy   dcache load        30 00000000 -    aaaa0000 00000000 00000000 00000000
